/* Makefile */
# Verilator build and run of the data-TLB testbench

SIM  := obj_dir/Vdtlb_tb
SRCS := $(shell cat sources.f)

.PHONY: run clean

run: $(SIM) verif/dtlb_tests.txt
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --top-module dtlb_tb -f sources.f -o Vdtlb_tb

clean:
	rm -rf obj_dir sim.log

/* hw/dtlb_entry_array.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fully associative translation storage of the data TLB
// Matches a lookup against all valid tags and registers the result
// Takes refill writes into the victim row and clears on flush
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dtlb_entry_array #(
  parameter int N = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  tlb_types_pkg::lookup_req_t    lookup_i,
  input  logic                          flush_i,
  input  tlb_types_pkg::refill_t        refill_i,
  input  logic [N-1:0]                  replace_vec_i,
  output logic [N-1:0]                  valid_vec_o,
  output logic [N-1:0]                  hit_vec_o,
  output logic                          hit_o,
  output logic                          lookup_done_o,
  output logic [tlb_cfg_pkg::PPN_W-1:0] ppn_o
);

  // Tag and translation per row
  logic [tlb_cfg_pkg::VPN_W-1:0] tag_q [N];
  logic [tlb_cfg_pkg::PPN_W-1:0] ppn_q [N];
  logic [N-1:0]                  valid_q;

  // Combinational match
  logic [N-1:0]                  match;
  logic [tlb_cfg_pkg::PPN_W-1:0] match_ppn;

  // Registered lookup result
  logic [N-1:0]                  hit_vec_q;
  logic                          hit_q;
  logic                          done_q;
  logic [tlb_cfg_pkg::PPN_W-1:0] rd_ppn_q;

  // At most one row matches, so an OR of the rows is the mux
  always_comb begin
    match     = '0;
    match_ppn = '0;
    for (int i = 0; i < N; i++) begin
      if (valid_q[i] && (tag_q[i] == lookup_i.vpn)) begin
        match[i]  = 1'b1;
        match_ppn = match_ppn | ppn_q[i];
      end
    end
  end

  // Lookup strobes, cleared when no lookup came in
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_vec_q <= '0;
      hit_q     <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      hit_vec_q <= lookup_i.valid ? match : '0;
      hit_q     <= lookup_i.valid & (|match);
      done_q    <= lookup_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_i.valid) begin
      rd_ppn_q <= match_ppn;
    end
  end

  // Valid bits, flush and refill never meet since flush waits for idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (refill_i.we) begin
      valid_q <= valid_q | replace_vec_i;
    end
  end

  // Row payload written by the refill
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N; i++) begin
      if (refill_i.we && replace_vec_i[i]) begin
        tag_q[i] <= refill_i.vpn;
        ppn_q[i] <= refill_i.ppn;
      end
    end
  end

  assign valid_vec_o   = valid_q;
  assign hit_vec_o     = hit_vec_q;
  assign hit_o         = hit_q;
  assign lookup_done_o = done_q;
  assign ppn_o         = rd_ppn_q;

endmodule

/* hw/dtlb_miss_fsm.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Miss handling of the data TLB
// Turns array results into responses and runs one walk per miss
// A walk ends with a refill write or with a fault on timeout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dtlb_miss_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          lookup_done_i,
  input  logic                          hit_i,
  input  logic [tlb_cfg_pkg::PPN_W-1:0] ppn_i,
  input  logic [tlb_cfg_pkg::VPN_W-1:0] lookup_vpn_i,
  input  tlb_types_pkg::ptw_rsp_t       ptw_rsp_i,
  input  logic                          expired_i,
  output tlb_types_pkg::ptw_req_t       ptw_req_o,
  output tlb_types_pkg::refill_t        refill_o,
  output logic                          timer_start_o,
  output logic                          timer_stop_o,
  output tlb_types_pkg::lookup_rsp_t    rsp_o,
  output logic                          busy_o
);

  tlb_types_pkg::miss_state_e    state_q, state_d;
  tlb_types_pkg::lookup_rsp_t    rsp_q, rsp_d;
  tlb_types_pkg::ptw_req_t       req_q;
  logic [tlb_cfg_pkg::VPN_W-1:0] vpn_q;
  logic [tlb_cfg_pkg::PPN_W-1:0] fill_ppn_q;
  logic                          idle;
  logic                          miss;

  assign idle = (state_q == tlb_types_pkg::IDLE);
  // Results arriving while a walk runs are dropped
  assign miss = idle & lookup_done_i & ~hit_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      tlb_types_pkg::IDLE:  if (miss) state_d = tlb_types_pkg::WALK;
      tlb_types_pkg::WALK: begin
        // Walker answer wins over a same-cycle expiry
        if (ptw_rsp_i.valid) begin
          state_d = tlb_types_pkg::FILL;
        end else if (expired_i) begin
          state_d = tlb_types_pkg::FAULT;
        end
      end
      default: state_d = tlb_types_pkg::IDLE;
    endcase
  end

  // Next response: hit, refilled translation or fault
  always_comb begin
    rsp_d = '0;
    if (idle && lookup_done_i && hit_i) begin
      rsp_d.valid = 1'b1;
      rsp_d.hit   = 1'b1;
      rsp_d.ppn   = ppn_i;
    end else if (state_q == tlb_types_pkg::FILL) begin
      rsp_d.valid = 1'b1;
      rsp_d.hit   = 1'b1;
      rsp_d.ppn   = fill_ppn_q;
    end else if (state_q == tlb_types_pkg::FAULT) begin
      rsp_d.valid = 1'b1;
      rsp_d.fault = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tlb_types_pkg::IDLE;
      rsp_q   <= '0;
      req_q   <= '0;
    end else begin
      state_q     <= state_d;
      rsp_q       <= rsp_d;
      req_q.valid <= miss;
      req_q.vpn   <= vpn_q;
    end
  end

  // VPN follows the lookup port until a miss freezes it for the walk
  always_ff @(posedge clk_i) begin
    if (idle && !miss) begin
      vpn_q <= lookup_vpn_i;
    end
    if ((state_q == tlb_types_pkg::WALK) && ptw_rsp_i.valid) begin
      fill_ppn_q <= ptw_rsp_i.ppn;
    end
  end

  assign refill_o.we   = (state_q == tlb_types_pkg::FILL);
  assign refill_o.vpn  = vpn_q;
  assign refill_o.ppn  = fill_ppn_q;

  assign timer_start_o = miss;
  assign timer_stop_o  = (state_q == tlb_types_pkg::WALK) & (ptw_rsp_i.valid | expired_i);

  assign ptw_req_o     = req_q;
  assign rsp_o         = rsp_q;
  assign busy_o        = ~idle;

endmodule

/* hw/dtlb_refill_timer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Walk timeout counter of the data TLB
// Armed by the start pulse, pulses expired after TIMEOUT cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dtlb_refill_timer #(
  parameter int TIMEOUT = 64
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);

  localparam int CNT_W = $clog2(TIMEOUT + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             armed_q;
  logic             expired_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      armed_q   <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      // Pulse lasts one cycle only
      expired_q <= 1'b0;
      if (start_i) begin
        cnt_q   <= '0;
        armed_q <= 1'b1;
      end else if (stop_i) begin
        armed_q <= 1'b0;
      end else if (armed_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Last wait cycle, disarm and signal
        if (cnt_q == CNT_W'(TIMEOUT - 1)) begin
          armed_q   <= 1'b0;
          expired_q <= 1'b1;
        end
      end
    end
  end

  assign expired_o = expired_q;

endmodule

/* hw/dtlb_replacement_block.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Victim selection for the data TLB
// Invalid entries are filled first, lowest index wins
// With a full TLB a tree pseudo-LRU picks the victim
// The tree moves away from each hit and from each refilled entry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dtlb_replacement_block #(
  parameter int N = 8
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Entry state and access strobes
  input  logic [N-1:0] tlb_valid_vec_i,
  input  logic         valid_tlb_read_i,
  input  logic         valid_tlb_replacement_i,
  input  logic [N-1:0] hit_vec_i,
  // One-hot victim
  output logic [N-1:0] replace_vec_o
);

  localparam int LOG2_N = $clog2(N);
  // Internal nodes first, then the N leaves, heap order
  localparam int NODES  = 2 * N - 1;

  // Tree bits, zero points to the lower half
  logic [N-2:0]     tree_q;
  logic [N-2:0]     tree_en;
  logic [N-2:0]     tree_d;

  // Node on the victim path
  logic [NODES-1:0] path_en;
  // Node above the accessed leaf
  logic [NODES-1:0] touched;

  logic [N-1:0]     plru_vec;
  logic [N-1:0]     inv_vec;
  logic [N-1:0]     replace_vec;
  logic [N-1:0]     access_vec;
  logic             access_valid;

  // Walk down the tree level by level
  always_comb begin
    path_en    = '0;
    path_en[0] = 1'b1;
    for (int lvl = 0; lvl < LOG2_N; lvl++) begin
      for (int k = (1 << lvl) - 1; k < (1 << (lvl + 1)) - 1; k++) begin
        path_en[2*k+1] = path_en[k] & ~tree_q[k];
        path_en[2*k+2] = path_en[k] &  tree_q[k];
      end
    end
  end

  // Leaves in ascending entry order
  assign plru_vec = path_en[NODES-1:N-1];

  // Lowest invalid entry, scanned from the top so index 0 wins
  always_comb begin
    inv_vec = '0;
    for (int k = N - 1; k >= 0; k--) begin
      if (!tlb_valid_vec_i[k]) begin
        inv_vec    = '0;
        inv_vec[k] = 1'b1;
      end
    end
  end

  assign replace_vec   = (&tlb_valid_vec_i) ? plru_vec : inv_vec;
  assign replace_vec_o = replace_vec;

  // Refill takes the victim, a read takes the hit entry
  always_comb begin
    access_vec = '0;
    if (valid_tlb_replacement_i) begin
      access_vec = replace_vec;
    end else if (valid_tlb_read_i) begin
      access_vec = hit_vec_i;
    end
  end

  assign access_valid = valid_tlb_read_i | valid_tlb_replacement_i;

  // Mark the path from the accessed leaf up to the root
  always_comb begin
    touched            = '0;
    touched[NODES-1:N-1] = access_vec;
    tree_d             = '0;
    for (int lvl = LOG2_N - 1; lvl >= 0; lvl--) begin
      for (int k = (1 << lvl) - 1; k < (1 << (lvl + 1)) - 1; k++) begin
        touched[k] = touched[2*k+1] | touched[2*k+2];
        // Came from the lower child, so point to the upper one
        tree_d[k]  = touched[2*k+1];
      end
    end
  end

  assign tree_en = touched[N-2:0];

  // Only nodes on the accessed path change
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tree_q <= '0;
    end else if (access_valid) begin
      tree_q <= (tree_q & ~tree_en) | (tree_d & tree_en);
    end
  end

endmodule

/* hw/dtlb_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data-TLB slice for the load/store unit
// Entry array, victim choice, walk timer and miss handling
// Lookups and flushes are taken only while busy_o is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dtlb_top #(
  parameter int N       = tlb_cfg_pkg::DTLB_ENTRIES,
  parameter int TIMEOUT = tlb_cfg_pkg::REFILL_TIMEOUT
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  tlb_types_pkg::lookup_req_t lookup_i,
  input  logic                       flush_i,
  input  tlb_types_pkg::ptw_rsp_t    ptw_rsp_i,
  output tlb_types_pkg::lookup_rsp_t rsp_o,
  output tlb_types_pkg::ptw_req_t    ptw_req_o,
  output logic                       busy_o
);

  tlb_types_pkg::lookup_req_t    lookup_gated;
  tlb_types_pkg::refill_t        refill;
  logic                          flush_gated;
  logic [N-1:0]                  valid_vec;
  logic [N-1:0]                  hit_vec;
  logic [N-1:0]                  replace_vec;
  logic                          hit;
  logic                          lookup_done;
  logic [tlb_cfg_pkg::PPN_W-1:0] ppn;
  logic                          timer_start;
  logic                          timer_stop;
  logic                          expired;

  // Drop caller traffic while a miss is outstanding
  assign lookup_gated.valid = lookup_i.valid & ~busy_o;
  assign lookup_gated.vpn   = lookup_i.vpn;
  assign flush_gated        = flush_i & ~busy_o;

  dtlb_entry_array #(.N(N)) u_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup_gated),
    .flush_i       (flush_gated),
    .refill_i      (refill),
    .replace_vec_i (replace_vec),
    .valid_vec_o   (valid_vec),
    .hit_vec_o     (hit_vec),
    .hit_o         (hit),
    .lookup_done_o (lookup_done),
    .ppn_o         (ppn)
  );

  // Registered hit is the read strobe, refill write the replacement strobe
  dtlb_replacement_block #(.N(N)) u_repl (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .tlb_valid_vec_i         (valid_vec),
    .valid_tlb_read_i        (hit),
    .valid_tlb_replacement_i (refill.we),
    .hit_vec_i               (hit_vec),
    .replace_vec_o           (replace_vec)
  );

  dtlb_refill_timer #(.TIMEOUT(TIMEOUT)) u_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (timer_start),
    .stop_i    (timer_stop),
    .expired_o (expired)
  );

  dtlb_miss_fsm u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_done_i (lookup_done),
    .hit_i         (hit),
    .ppn_i         (ppn),
    .lookup_vpn_i  (lookup_i.vpn),
    .ptw_rsp_i     (ptw_rsp_i),
    .expired_i     (expired),
    .ptw_req_o     (ptw_req_o),
    .refill_o      (refill),
    .timer_start_o (timer_start),
    .timer_stop_o  (timer_stop),
    .rsp_o         (rsp_o),
    .busy_o        (busy_o)
  );

endmodule

/* hw/tlb_cfg_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration constants of the data-TLB slice
// Sizes of the translation fields and default depth and walk timeout
// Referenced by scoped name from the types package and the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package tlb_cfg_pkg;

  // Default number of TLB entries
  // Must stay a power of two for the pseudo-LRU tree
  localparam int DTLB_ENTRIES = 8;

  // Virtual page number width
  localparam int VPN_W = 20;

  // Physical page number width
  localparam int PPN_W = 20;

  // Walker wait cycles before the walk is treated as lost
  localparam int REFILL_TIMEOUT = 64;

endpackage

/* hw/tlb_types_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data types carried between the TLB slice, its caller and the walker
// Lookup, response, walker request and refill bundles plus miss states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package tlb_types_pkg;

  // Lookup from the load/store unit
  typedef struct packed {
    logic                         valid;
    logic [tlb_cfg_pkg::VPN_W-1:0] vpn;
  } lookup_req_t;

  // Lookup result, hit and fault are exclusive
  typedef struct packed {
    logic                         valid;
    logic                         hit;
    logic                         fault;
    logic [tlb_cfg_pkg::PPN_W-1:0] ppn;
  } lookup_rsp_t;

  // Request towards the page-table walker
  typedef struct packed {
    logic                         valid;
    logic [tlb_cfg_pkg::VPN_W-1:0] vpn;
  } ptw_req_t;

  // Answer from the page-table walker
  typedef struct packed {
    logic                         valid;
    logic [tlb_cfg_pkg::PPN_W-1:0] ppn;
  } ptw_rsp_t;

  // Write into the entry array
  typedef struct packed {
    logic                         we;
    logic [tlb_cfg_pkg::VPN_W-1:0] vpn;
    logic [tlb_cfg_pkg::PPN_W-1:0] ppn;
  } refill_t;

  // Miss handling states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    WALK  = 2'd1,
    FILL  = 2'd2,
    FAULT = 2'd3
  } miss_state_e;

endpackage

/* sources.f */
hw/tlb_cfg_pkg.sv
hw/tlb_types_pkg.sv
hw/dtlb_replacement_block.sv
hw/dtlb_entry_array.sv
hw/dtlb_refill_timer.sv
hw/dtlb_miss_fsm.sv
hw/dtlb_top.sv
verif/dtlb_tb.sv

/* verif/dtlb_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the data-TLB slice
// Reads operations from verif/dtlb_tests.txt, plays the page-table walker
// and checks every response against a reference model of the TLB
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dtlb_tb;

  localparam int    N          = tlb_cfg_pkg::DTLB_ENTRIES;
  localparam int    CLK_PERIOD = 8;
  localparam string TEST_FILE  = "verif/dtlb_tests.txt";

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       flush;
  logic                       busy;
  tlb_types_pkg::lookup_req_t lookup;
  tlb_types_pkg::ptw_rsp_t    ptw_rsp;
  tlb_types_pkg::lookup_rsp_t rsp;
  tlb_types_pkg::ptw_req_t    ptw_req;

  // Operations read from the data file
  byte                           t_op [$];
  byte                           t_exp [$];
  logic [tlb_cfg_pkg::VPN_W-1:0] t_vpn [$];
  logic [tlb_cfg_pkg::PPN_W-1:0] t_ppn [$];
  int                            t_dly [$];

  // Reference model, tags, translations, valid bits and tree
  logic [tlb_cfg_pkg::VPN_W-1:0] m_tag [N];
  logic [tlb_cfg_pkg::PPN_W-1:0] m_ppn [N];
  logic [N-1:0]                  m_valid;
  logic [N-2:0]                  m_tree;

  // Pulses seen on the DUT outputs
  int                         req_cnt = 0;
  int                         rsp_cnt = 0;
  tlb_types_pkg::ptw_req_t    last_req;
  tlb_types_pkg::lookup_rsp_t last_rsp;

  int    errors  = 0;
  int    checks  = 0;
  int    max_dly = 0;
  string detail;

  dtlb_top u_dut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .lookup_i  (lookup),
    .flush_i   (flush),
    .ptw_rsp_i (ptw_rsp),
    .rsp_o     (rsp),
    .ptw_req_o (ptw_req),
    .busy_o    (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Outputs are registered, so the edge sees last cycle's values
  always @(posedge clk) begin
    if (ptw_req.valid) begin
      req_cnt  <= req_cnt + 1;
      last_req <= ptw_req;
    end
    if (rsp.valid) begin
      rsp_cnt  <= rsp_cnt + 1;
      last_rsp <= rsp;
    end
  end

  task automatic check_rsp(tlb_types_pkg::lookup_rsp_t got, tlb_types_pkg::lookup_rsp_t exp,
                           string what);
    checks++;
    // PPN only means something on a hit
    if (got.valid !== exp.valid || got.hit !== exp.hit || got.fault !== exp.fault ||
        (exp.hit && got.ppn !== exp.ppn)) begin
      errors++;
      $display("[FAIL] %0t: %s response v%b h%b f%b ppn %h, expected v%b h%b f%b ppn %h",
               $time, what, got.valid, got.hit, got.fault, got.ppn,
               exp.valid, exp.hit, exp.fault, exp.ppn);
    end
  endtask

  task automatic check_req(tlb_types_pkg::ptw_req_t got, tlb_types_pkg::ptw_req_t exp,
                           string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s walker request v%b vpn %h, expected v%b vpn %h",
               $time, what, got.valid, got.vpn, exp.valid, exp.vpn);
    end
  endtask

  task automatic check_level(logic got, logic exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(int got, int exp, string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Entry holding the VPN, -1 on a miss
  function automatic int find_entry(logic [tlb_cfg_pkg::VPN_W-1:0] vpn);
    for (int e = 0; e < N; e++) begin
      if (m_valid[e] && m_tag[e] == vpn) begin
        return e;
      end
    end
    return -1;
  endfunction

  // Lowest invalid entry, else follow the tree from the root
  function automatic int pick_victim();
    int node;
    for (int e = 0; e < N; e++) begin
      if (!m_valid[e]) begin
        return e;
      end
    end
    node = 0;
    while (node < N - 1) begin
      node = m_tree[node] ? 2 * node + 2 : 2 * node + 1;
    end
    return node - (N - 1);
  endfunction

  // Every node on the path points away from the accessed entry
  function automatic void touch_entry(int e);
    int node;
    int parent;
    node = e + N - 1;
    while (node > 0) begin
      parent         = (node - 1) / 2;
      m_tree[parent] = (node == 2 * parent + 1);
      node           = parent;
    end
  endfunction

  task automatic load_tests();
    int                            fd;
    int                            dly;
    string                         line;
    logic [tlb_cfg_pkg::VPN_W-1:0] vpn;
    logic [tlb_cfg_pkg::PPN_W-1:0] ppn;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test file %s", TEST_FILE);
    end else begin
      while ($fgets(line, fd) > 0) begin
        // Columns are op, expected outcome, then the numbers
        if (line.len() >= 5 && line[0] != "#") begin
          void'($sscanf(line.substr(4, line.len() - 1), "%h %h %d", vpn, ppn, dly));
          t_op.push_back(line[0]);
          t_exp.push_back(line[2]);
          t_vpn.push_back(vpn);
          t_ppn.push_back(ppn);
          t_dly.push_back(dly);
          if (dly > max_dly) begin
            max_dly = dly;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Walker answer after the delay, B lines add lookups that must be dropped
  task automatic play_walker(int i);
    for (int d = 0; d < t_dly[i]; d++) begin
      if (t_op[i] == "B" && busy) begin
        lookup.valid = 1'b1;
        lookup.vpn   = m_tag[d % N];
      end
      @(negedge clk);
    end
    lookup.valid  = 1'b0;
    ptw_rsp.valid = 1'b1;
    ptw_rsp.ppn   = t_ppn[i];
    @(negedge clk);
    ptw_rsp = '0;
  endtask

  task automatic run_lookup(int i);
    int                         req0;
    int                         rsp0;
    int                         idx;
    int                         victim;
    bit                         model_hit;
    string                      tag;
    tlb_types_pkg::lookup_rsp_t exp_rsp;
    tlb_types_pkg::ptw_req_t    exp_req;
    tag       = $sformatf("test %0d vpn %h", i, t_vpn[i]);
    idx       = find_entry(t_vpn[i]);
    model_hit = (idx >= 0);
    if (model_hit != (t_exp[i] == "H")) begin
      errors++;
      $display("%s: data file expects %c but the model predicts a %s",
               tag, t_exp[i], model_hit ? "hit" : "miss");
    end
    exp_rsp       = '0;
    exp_rsp.valid = 1'b1;
    if (model_hit) begin
      exp_rsp.hit = 1'b1;
      exp_rsp.ppn = m_ppn[idx];
    end else if (t_op[i] == "N") begin
      exp_rsp.fault = 1'b1;
    end else begin
      exp_rsp.hit = 1'b1;
      exp_rsp.ppn = t_ppn[i];
    end
    req0         = req_cnt;
    rsp0         = rsp_cnt;
    lookup.valid = 1'b1;
    lookup.vpn   = t_vpn[i];
    @(negedge clk);
    lookup.valid = 1'b0;
    while (req_cnt == req0 && rsp_cnt == rsp0) begin
      @(negedge clk);
    end
    if (!model_hit) begin
      exp_req.valid = 1'b1;
      exp_req.vpn   = t_vpn[i];
      check_req(last_req, exp_req, tag);
      check_level(busy, 1'b1, {tag, " busy during walk"});
      // A silent walker leaves the timer to end the walk
      if (t_op[i] != "N") begin
        play_walker(i);
      end
    end
    while (rsp_cnt == rsp0) begin
      @(negedge clk);
    end
    check_rsp(last_rsp, exp_rsp, tag);
    repeat (3) @(negedge clk);
    check_count(rsp_cnt - rsp0, 1, {tag, " response"});
    check_count(req_cnt - req0, model_hit ? 0 : 1, {tag, " walker request"});
    check_level(busy, 1'b0, {tag, " busy after response"});
    // Faulted walk writes nothing
    if (model_hit) begin
      touch_entry(idx);
      detail = $sformatf("hit entry %0d", idx);
    end else if (t_op[i] != "N") begin
      victim          = pick_victim();
      m_tag[victim]   = t_vpn[i];
      m_ppn[victim]   = t_ppn[i];
      m_valid[victim] = 1'b1;
      touch_entry(victim);
      detail = $sformatf("refill entry %0d", victim);
    end else begin
      detail = "fault";
    end
  endtask

  task automatic run_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    @(negedge clk);
    m_valid = '0;
    detail  = "flush";
  endtask

  initial begin
    int err0;
    int limit;
    rst_n    = 1'b0;
    flush    = 1'b0;
    lookup   = '0;
    ptw_rsp  = '0;
    m_valid  = '0;
    m_tree   = '0;
    load_tests();
    if (t_op.size() == 0) begin
      errors++;
      $display("no tests were read from %s", TEST_FILE);
    end else begin
      // Worst case per test is a full walk timeout plus the slowest walker
      limit = t_op.size() * (tlb_cfg_pkg::REFILL_TIMEOUT + max_dly + 8) + 16;
      fork
        begin
          repeat (limit) @(posedge clk);
          $display("watchdog stopped the run after %0d cycles without finishing", limit);
          $display("TEST RESULT: FAIL");
          $finish;
        end
      join_none
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      for (int i = 0; i < t_op.size(); i++) begin
        err0   = errors;
        detail = "";
        case (t_op[i])
          "F":           run_flush();
          "L", "B", "N": run_lookup(i);
          default: begin
            errors++;
            $display("test %0d has an unknown operation %c", i, t_op[i]);
          end
        endcase
        $display("test %0d %c vpn %h %s: %s", i, t_op[i], t_vpn[i], detail,
                 (errors == err0) ? "ok" : "failed");
      end
    end
    $display("tests %0d, checks %0d, errors %0d", t_op.size(), checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verif/dtlb_tests.txt */
# op exp vpn ppn delay; op L lookup, B lookup with dropped lookups while busy, N silent walker, F flush
# exp H hit, M miss and refill, X fault, - none; ppn and delay are the walker answer to a miss
L M 00010 a0010 3
L M 00011 a0011 0
L M 00012 a0012 5
L M 00013 a0013 1
L M 00014 a0014 9
L M 00015 a0015 2
L M 00016 a0016 4
L M 00017 a0017 7
L H 00010 00000 0
L H 00011 00000 0
L H 00012 00000 0
L H 00013 00000 0
L H 00014 00000 0
L H 00015 00000 0
L H 00016 00000 0
L H 00017 00000 0
L H 00010 00000 0
L H 00014 00000 0
L H 00012 00000 0
L M 00020 a0020 2
L M 00016 b0016 3
L H 00010 00000 0
L H 00020 00000 0
L H 00017 00000 0
N X 00030 00000 0
L M 00030 a0030 6
B M 00031 a0031 8
F - 00000 00000 0
L M 00010 b0010 1
L M 00012 b0012 0
L M 00020 b0020 2
L H 00010 00000 0
L M 00017 b0017 3
